// File: files.f
logic/ooo_pkg.sv
logic/dispatch_stage.sv
logic/res_station.sv
logic/alu_stage.sv
logic/issue_top.sv
tb/tb_clock_gen.sv
tb/tb_issue.sv

// File: Bender.yml
package:
  name: ooo_issue

sources:
  - logic/ooo_pkg.sv
  - logic/dispatch_stage.sv
  - logic/res_station.sv
  - logic/alu_stage.sv
  - logic/issue_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_issue.sv

// File: tb/tb_issue.sv
`timescale 1ns/10ps

module tb_issue;

    localparam int CLK_PERIOD = 20;
    localparam int TW         = ooo_pkg::TAG_W;
    localparam int DW         = ooo_pkg::XLEN;
    localparam int NP         = ooo_pkg::CDB_PORTS;
    localparam int N_STREAM   = 16;
    localparam int N_CHAIN    = 4;
    localparam int N_STALLED  = 12;
    // Chain head, three wakeup cases, three flushed and four after flush
    localparam int N_INSTR    = N_STREAM + N_CHAIN + N_STALLED + 11;

    logic              clk;
    logic              reset;
    logic              flush;
    logic              stall;
    logic              in_valid;
    ooo_pkg::opcode_e  in_op;
    logic              in_a_renamed;
    ooo_pkg::operand_u in_a;
    logic              in_b_renamed;
    ooo_pkg::operand_u in_b;
    logic              in_ready;
    logic [NP-2:0]     ext_valid;
    logic [TW-1:0]     ext_tag [NP-1];
    logic [DW-1:0]     ext_data [NP-1];
    logic              result_valid;
    logic [TW-1:0]     result_tag;
    logic [DW-1:0]     result_data;

    // Reference model keeps the oldest outstanding instruction at the head
    logic [TW-1:0]     exp_tag_q [$];
    logic [DW-1:0]     exp_data_q [$];
    logic              head_valid;
    logic [TW-1:0]     head_tag;
    logic [DW-1:0]     head_data;
    logic [TW-1:0]     model_tag;
    logic              first_seen;
    logic [DW-1:0]     a_val;
    logic [DW-1:0]     b_val;
    logic [31:0]       lfsr;
    logic              stall_on;

    tb_clock_gen #(.period(CLK_PERIOD), .reset_cycles(3)) u_clk (.clk, .reset);

    issue_top #(.data_w(DW), .tag_w(TW), .cdb_ports(NP)) uut (.*);

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // av and bv are the values the operands finally take
    task automatic send(input ooo_pkg::opcode_e op, input logic ar, input logic [DW-1:0] a,
                        input logic br, input logic [DW-1:0] b,
                        input logic [DW-1:0] av, input logic [DW-1:0] bv);
        in_valid     = 1'b1;
        in_op        = op;
        in_a_renamed = ar;
        in_a         = a;
        in_b_renamed = br;
        in_b         = b;
        a_val        = av;
        b_val        = bv;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
        #2 in_valid = 1'b0;
    endtask

    task automatic send_random();
        ooo_pkg::opcode_e op;
        logic [DW-1:0]    a;
        logic [DW-1:0]    b;
        op = ooo_pkg::opcode_e'(rand_bits(3));
        a  = rand_bits(32);
        b  = rand_bits(32);
        send(op, 1'b0, a, 1'b0, b, a, b);
    endtask

    task automatic broadcast(input logic [TW-1:0] tag, input logic [DW-1:0] data);
        ext_valid[0] = 1'b1;
        ext_tag[0]   = tag;
        ext_data[0]  = data;
        @(posedge clk);
        #2 ext_valid[0] = 1'b0;
    endtask

    task automatic drain();
        while (exp_tag_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            exp_tag_q.delete();
            exp_data_q.delete();
            model_tag  = '0;
            first_seen = 1'b0;
        end else begin
            if (result_valid && exp_tag_q.size() != 0) begin
                void'(exp_tag_q.pop_front());
                void'(exp_data_q.pop_front());
            end
            // Flush drops everything accepted so far
            if (flush) begin
                exp_tag_q.delete();
                exp_data_q.delete();
            end
            if (in_valid && in_ready) begin
                if (!flush) begin
                    exp_tag_q.push_back(model_tag);
                    exp_data_q.push_back(ooo_pkg::alu_op(in_op, a_val, b_val));
                end
                model_tag  = model_tag + 1'b1;
                first_seen = 1'b1;
            end
        end
        head_valid = (exp_tag_q.size() != 0);
        head_tag   = head_valid ? exp_tag_q[0] : '0;
        head_data  = head_valid ? exp_data_q[0] : '0;
    end

    a_result_owned: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> head_valid)
        else report_error($sformatf("Result at %0t with no instruction outstanding", $time));
    a_result_tag: assert property (@(posedge clk) disable iff (reset)
        result_valid && head_valid |-> result_tag == head_tag)
        else report_error($sformatf("FAIL %0t result_tag expected %0h actual %0h",
                                    $time, $sampled(head_tag), $sampled(result_tag)));
    a_result_data: assert property (@(posedge clk) disable iff (reset)
        result_valid && head_valid |-> result_data == head_data)
        else report_error($sformatf("FAIL %0t result_data expected %0h actual %0h",
                                    $time, $sampled(head_data), $sampled(result_data)));
    a_stall_quiet: assert property (@(posedge clk) disable iff (reset)
        stall |=> !result_valid)
        else report_error($sformatf("FAIL %0t result_valid expected 0 actual 1", $time));
    a_flush_quiet: assert property (@(posedge clk) disable iff (reset)
        flush |=> !result_valid)
        else report_error($sformatf("FAIL %0t result_valid expected 0 actual 1", $time));
    a_flush_ready: assert property (@(posedge clk) disable iff (reset)
        flush |=> in_ready)
        else report_error($sformatf("FAIL %0t in_ready expected 1 actual 0", $time));
    a_idle_ready: assert property (@(posedge clk) disable iff (reset)
        !first_seen |-> in_ready && !result_valid)
        else report_error($sformatf("FAIL %0t in_ready/result_valid expected 1/0 actual %0b/%0b",
                                    $time, $sampled(in_ready), $sampled(result_valid)));

    // Stall pattern changes a little later in the cycle than the main stimulus
    initial begin
        forever begin
            @(posedge clk);
            #3 stall = stall_on && (rand_bits(1) != 0);
        end
    end

    initial begin
        #(N_INSTR * 200 * CLK_PERIOD);
        report_error("Run timed out before all instructions completed");
    end

    initial begin
        ooo_pkg::opcode_e op;
        logic [TW-1:0]    t0;
        logic [TW-1:0]    t1;
        logic [DW-1:0]    v0;
        logic [DW-1:0]    v1;
        logic [DW-1:0]    b;
        lfsr         = 32'h9af0;
        stall_on     = 1'b0;
        flush        = 1'b0;
        stall        = 1'b0;
        in_valid     = 1'b0;
        in_op        = ooo_pkg::op_add;
        in_a_renamed = 1'b0;
        in_a         = '0;
        in_b_renamed = 1'b0;
        in_b         = '0;
        a_val        = '0;
        b_val        = '0;
        ext_valid    = '0;
        ext_tag[0]   = '0;
        ext_data[0]  = '0;
        @(negedge reset);
        repeat (3) @(posedge clk);
        #2;
        repeat (N_STREAM) send_random();
        drain();
        // Each link waits on the previous destination tag
        op = ooo_pkg::opcode_e'(rand_bits(3));
        v1 = rand_bits(32);
        b  = rand_bits(32);
        send(op, 1'b0, v1, 1'b0, b, v1, b);
        v0 = ooo_pkg::alu_op(op, v1, b);
        repeat (N_CHAIN) begin
            op = ooo_pkg::opcode_e'(rand_bits(3));
            b  = rand_bits(32);
            t0 = model_tag - 1'b1;
            send(op, 1'b1, DW'(t0), 1'b0, b, v0, b);
            v0 = ooo_pkg::alu_op(op, v0, b);
        end
        drain();
        // First waits in the RS, second behind it in dispatch
        t0 = model_tag + 4'd8;
        t1 = t0 + 1'b1;
        v0 = rand_bits(32);
        v1 = rand_bits(32);
        b  = rand_bits(32);
        send(ooo_pkg::op_sub, 1'b1, DW'(t0), 1'b0, b, v0, b);
        send(ooo_pkg::op_xor, 1'b0, b, 1'b1, DW'(t1), b, v1);
        broadcast(t1, v1);
        broadcast(t0, v0);
        drain();
        // Broadcast lands on the dispatch to RS move
        t0 = model_tag + 4'd8;
        v0 = rand_bits(32);
        send(ooo_pkg::op_add, 1'b1, DW'(t0), 1'b1, DW'(t0), v0, v0);
        broadcast(t0, v0);
        drain();
        // Flush lands while the ALU fires, the RS holds a stuck entry and dispatch takes one more
        send_random();
        t0 = model_tag + 4'd8;
        send(ooo_pkg::op_or, 1'b1, DW'(t0), 1'b0, 32'h1, '0, 32'h1);
        flush = 1'b1;
        send_random();
        flush = 1'b0;
        repeat (4) send_random();
        drain();
        stall_on = 1'b1;
        repeat (N_STALLED) send_random();
        stall_on = 1'b0;
        drain();
        repeat (4) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period       = 20,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset drops just after an edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #2 reset = 1'b0;
    end

endmodule

// File: logic/issue_top.sv
`timescale 1ns/10ps

module issue_top #(
    parameter int data_w    = ooo_pkg::XLEN,
    parameter int tag_w     = ooo_pkg::TAG_W,
    parameter int cdb_ports = ooo_pkg::CDB_PORTS
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 stall,
    input  logic                 in_valid,
    input  ooo_pkg::opcode_e     in_op,
    input  logic                 in_a_renamed,
    input  ooo_pkg::operand_u    in_a,
    input  logic                 in_b_renamed,
    input  ooo_pkg::operand_u    in_b,
    output logic                 in_ready,
    input  logic [cdb_ports-2:0] ext_valid,
    input  logic [tag_w-1:0]     ext_tag [cdb_ports-1],
    input  logic [data_w-1:0]    ext_data [cdb_ports-1],
    output logic                 result_valid,
    output logic [tag_w-1:0]     result_tag,
    output logic [data_w-1:0]    result_data
);

    logic [cdb_ports-1:0] cdb_valid;
    logic [tag_w-1:0]     cdb_tag [cdb_ports];
    logic [data_w-1:0]    cdb_data [cdb_ports];

    logic                 ds_valid;
    ooo_pkg::opcode_e     ds_op;
    logic [tag_w-1:0]     ds_tag;
    logic                 ds_a_renamed;
    ooo_pkg::operand_u    ds_a;
    logic                 ds_b_renamed;
    ooo_pkg::operand_u    ds_b;
    logic                 rs_write_rdy;
    logic                 rs_read_rdy;
    ooo_pkg::opcode_e     iss_op;
    logic [tag_w-1:0]     iss_tag;
    logic [data_w-1:0]    iss_a;
    logic [data_w-1:0]    iss_b;
    logic                 alu_re;

    // Port 0 belongs to the ALU, the rest come from outside
    always_comb begin
        cdb_valid[0] = result_valid;
        cdb_tag[0]   = result_tag;
        cdb_data[0]  = result_data;
        for (int p = 1; p < cdb_ports; p++) begin
            cdb_valid[p] = ext_valid[p-1];
            cdb_tag[p]   = ext_tag[p-1];
            cdb_data[p]  = ext_data[p-1];
        end
    end

    dispatch_stage #(.data_w(data_w), .tag_w(tag_w), .cdb_ports(cdb_ports)) u_dispatch (
        .clk, .reset, .flush,
        .in_valid, .in_op, .in_a_renamed, .in_a, .in_b_renamed, .in_b, .in_ready,
        .cdb_valid, .cdb_tag, .cdb_data,
        .ds_valid, .ds_op, .ds_tag, .ds_a_renamed, .ds_a, .ds_b_renamed, .ds_b,
        .rs_write_rdy, .stall
    );

    res_station #(.data_w(data_w), .tag_w(tag_w), .cdb_ports(cdb_ports)) u_rs (
        .clk, .reset, .flush, .stall,
        .ds_valid, .ds_op, .ds_tag, .ds_a_renamed, .ds_a, .ds_b_renamed, .ds_b,
        .rs_write_rdy, .cdb_valid, .cdb_tag, .cdb_data,
        .rs_read_rdy, .iss_op, .iss_tag, .iss_a, .iss_b, .alu_re
    );

    alu_stage #(.data_w(data_w), .tag_w(tag_w)) u_alu (
        .clk, .reset, .flush, .stall, .alu_re,
        .rs_read_rdy, .iss_op, .iss_tag, .iss_a, .iss_b,
        .res_valid(result_valid), .res_tag(result_tag), .res_data(result_data)
    );

endmodule

// File: logic/alu_stage.sv
`timescale 1ns/10ps

module alu_stage #(
    parameter int data_w = ooo_pkg::XLEN,
    parameter int tag_w  = ooo_pkg::TAG_W
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              stall,
    output logic              alu_re,
    input  logic              rs_read_rdy,
    input  ooo_pkg::opcode_e  iss_op,
    input  logic [tag_w-1:0]  iss_tag,
    input  logic [data_w-1:0] iss_a,
    input  logic [data_w-1:0] iss_b,
    output logic              res_valid,
    output logic [tag_w-1:0]  res_tag,
    output logic [data_w-1:0] res_data
);

    logic fire;

    // ALU is always free except under stall
    assign alu_re = !stall;
    assign fire   = rs_read_rdy && alu_re;

    // One result pulse per issue
    always_ff @(posedge clk) begin
        if (reset || flush)
            res_valid <= 1'b0;
        else
            res_valid <= fire;
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_tag  <= iss_tag;
            res_data <= ooo_pkg::alu_op(iss_op, iss_a, iss_b);
        end
    end

endmodule

// File: logic/res_station.sv
`timescale 1ns/10ps

module res_station #(
    parameter int data_w    = ooo_pkg::XLEN,
    parameter int tag_w     = ooo_pkg::TAG_W,
    parameter int cdb_ports = ooo_pkg::CDB_PORTS
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  stall,
    input  logic                  ds_valid,
    input  ooo_pkg::opcode_e      ds_op,
    input  logic [tag_w-1:0]      ds_tag,
    input  logic                  ds_a_renamed,
    input  ooo_pkg::operand_u     ds_a,
    input  logic                  ds_b_renamed,
    input  ooo_pkg::operand_u     ds_b,
    output logic                  rs_write_rdy,
    input  logic [cdb_ports-1:0]  cdb_valid,
    input  logic [tag_w-1:0]      cdb_tag [cdb_ports],
    input  logic [data_w-1:0]     cdb_data [cdb_ports],
    output logic                  rs_read_rdy,
    output ooo_pkg::opcode_e      iss_op,
    output logic [tag_w-1:0]      iss_tag,
    output logic [data_w-1:0]     iss_a,
    output logic [data_w-1:0]     iss_b,
    input  logic                  alu_re
);

    typedef enum logic {
        EMPTY,
        WAITING
    } rs_state_e;

    rs_state_e         state;
    logic              write;
    logic              issue;
    ooo_pkg::opcode_e  ent_op;
    logic [tag_w-1:0]  ent_tag;
    logic [1:0]        ent_ren;
    ooo_pkg::operand_u ent_opnd [2];

    // Operand candidates, either the incoming instruction or the held entry
    logic [1:0]           src_ren;
    ooo_pkg::operand_u    src_opnd [2];
    logic [cdb_ports-1:0] match [2];
    logic [1:0]           nxt_ren;
    ooo_pkg::operand_u    nxt_opnd [2];

    assign rs_read_rdy  = (state == WAITING) && !(|ent_ren);
    assign issue        = rs_read_rdy && alu_re;
    assign rs_write_rdy = (state == EMPTY) || (issue && !stall);
    assign write        = ds_valid && rs_write_rdy && !stall;

    // Wakeup compare, every operand against every CDB port
    always_comb begin
        src_ren[0]  = write ? ds_a_renamed : ent_ren[0];
        src_ren[1]  = write ? ds_b_renamed : ent_ren[1];
        src_opnd[0] = write ? ds_a : ent_opnd[0];
        src_opnd[1] = write ? ds_b : ent_opnd[1];
        for (int k = 0; k < 2; k++) begin
            nxt_ren[k]  = src_ren[k];
            nxt_opnd[k] = src_opnd[k];
            for (int p = 0; p < cdb_ports; p++) begin
                match[k][p] = src_ren[k] && cdb_valid[p] &&
                              (cdb_tag[p] == src_opnd[k].ren.tag);
                // Tags are unique on the bus, so at most one port matches
                if (match[k][p])
                    nxt_opnd[k].data = cdb_data[p];
            end
            if (|match[k])
                nxt_ren[k] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush)
            state <= EMPTY;
        else if (write)
            state <= WAITING;
        else if (issue)
            state <= EMPTY;
    end

    always_ff @(posedge clk) begin
        if (write) begin
            ent_op  <= ds_op;
            ent_tag <= ds_tag;
        end
        // Wakeup keeps going through a stall
        for (int k = 0; k < 2; k++) begin
            ent_ren[k]  <= nxt_ren[k];
            ent_opnd[k] <= nxt_opnd[k];
        end
    end

    assign iss_op  = ent_op;
    assign iss_tag = ent_tag;
    assign iss_a   = ent_opnd[0].data;
    assign iss_b   = ent_opnd[1].data;

endmodule

// File: logic/dispatch_stage.sv
`timescale 1ns/10ps

module dispatch_stage #(
    parameter int data_w    = ooo_pkg::XLEN,
    parameter int tag_w     = ooo_pkg::TAG_W,
    parameter int cdb_ports = ooo_pkg::CDB_PORTS
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  in_valid,
    input  ooo_pkg::opcode_e      in_op,
    input  logic                  in_a_renamed,
    input  ooo_pkg::operand_u     in_a,
    input  logic                  in_b_renamed,
    input  ooo_pkg::operand_u     in_b,
    output logic                  in_ready,
    input  logic [cdb_ports-1:0]  cdb_valid,
    input  logic [tag_w-1:0]      cdb_tag [cdb_ports],
    input  logic [data_w-1:0]     cdb_data [cdb_ports],
    output logic                  ds_valid,
    output ooo_pkg::opcode_e      ds_op,
    output logic [tag_w-1:0]      ds_tag,
    output logic                  ds_a_renamed,
    output ooo_pkg::operand_u     ds_a,
    output logic                  ds_b_renamed,
    output ooo_pkg::operand_u     ds_b,
    input  logic                  rs_write_rdy,
    input  logic                  stall
);

    logic              take;
    logic              leave;
    logic [tag_w-1:0]  next_tag;
    logic [1:0]        held_ren;
    ooo_pkg::operand_u held_opnd [2];
    logic [1:0]        hit;
    logic [data_w-1:0] hit_data [2];

    // Register frees up in the same cycle it hands off to the RS
    assign leave    = ds_valid && rs_write_rdy && !stall;
    assign in_ready = !ds_valid || leave;
    assign take     = in_valid && in_ready;

    // Snoop the CDB for operands still waiting on a producer
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            hit[k]      = 1'b0;
            hit_data[k] = held_opnd[k].data;
            for (int p = 0; p < cdb_ports; p++) begin
                if (held_ren[k] && cdb_valid[p] && (cdb_tag[p] == held_opnd[k].ren.tag)) begin
                    hit[k]      = 1'b1;
                    hit_data[k] = cdb_data[p];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
            next_tag <= '0;
        end else begin
            // Tag counter keeps running across a flush
            if (take)
                next_tag <= next_tag + 1'b1;
            if (flush)
                ds_valid <= 1'b0;
            else if (take)
                ds_valid <= 1'b1;
            else if (leave)
                ds_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ds_op        <= in_op;
            ds_tag       <= next_tag;
            held_ren[0]  <= in_a_renamed;
            held_opnd[0] <= in_a;
            held_ren[1]  <= in_b_renamed;
            held_opnd[1] <= in_b;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (hit[k]) begin
                    held_ren[k]       <= 1'b0;
                    held_opnd[k].data <= hit_data[k];
                end
            end
        end
    end

    assign ds_a_renamed = held_ren[0];
    assign ds_a         = held_opnd[0];
    assign ds_b_renamed = held_ren[1];
    assign ds_b         = held_opnd[1];

endmodule

// File: logic/ooo_pkg.sv
package ooo_pkg;

    // Core word and tag sizes, used as module parameter defaults
    parameter int XLEN      = 32;
    parameter int TAG_W     = 4;
    parameter int CDB_PORTS = 2;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_srl = 3'd6,
        op_slt = 3'd7
    } opcode_e;

    // Tag view of an operand word, tag in the low bits
    typedef struct packed {
        logic [XLEN-TAG_W-1:0] pad;
        logic [TAG_W-1:0]      tag;
    } renamed_t;

    // Renamed flag next to the word picks which member is live
    typedef union packed {
        logic [XLEN-1:0] data;
        renamed_t        ren;
    } operand_u;

    function automatic logic [XLEN-1:0] alu_op(
        input opcode_e         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic [XLEN-1:0] r;
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            op_sll:  r = a << b[4:0];
            op_srl:  r = a >> b[4:0];
            op_slt:  r = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            default: r = '0;
        endcase
        return r;
    endfunction

endpackage
